// File: Bender.yml
package:
  name: pixel_feeder

sources:
  - files:
      - source/frame_geom_pkg.sv
      - source/feeder_regs_pkg.sv
      - source/feeder_regs.sv
      - source/frame_fetcher.sv
      - source/pixel_fifo.sv
      - source/pixel_feeder_top.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_checker.sv
      - testbench/pixel_feeder_assertions.sv
      - testbench/tb_pixel_feeder.sv

// File: filelist.f
source/frame_geom_pkg.sv
source/feeder_regs_pkg.sv
source/feeder_regs.sv
source/frame_fetcher.sv
source/pixel_fifo.sv
source/pixel_feeder_top.sv
testbench/tb_clock_gen.sv
testbench/tb_checker.sv
testbench/pixel_feeder_assertions.sv
testbench/tb_pixel_feeder.sv

// File: source/feeder_regs.sv
`timescale 1ns/10ps
// APB slave for the pixel feeder
// holds the enables, the sticky frame-done flag, the frame counter and the interrupt
module feeder_regs (
   input  logic                                       cpu_clk_g,
   input  logic                                       rst,
   input  logic                                       psel,
   input  logic                                       penable,
   input  logic                                       pwrite,
   input  logic [feeder_regs_pkg::apb_addr_width-1:0] paddr,
   input  logic [feeder_regs_pkg::apb_data_width-1:0] pwdata,
   output logic [feeder_regs_pkg::apb_data_width-1:0] prdata,
   output logic                                       pready,
   output logic                                       pslverr,
   input  logic                                       frame_done,
   input  logic                                       active_buffer,
   output logic                                       fetch_enable,
   output logic                                       frame_irq
);
   import feeder_regs_pkg::*;

   logic                      access;
   logic                      wr_access;
   logic                      addr_hit;
   logic                      irq_en;
   logic                      done_flag;
   logic [apb_data_width-1:0] frame_count;
   logic [apb_data_width-1:0] rd_mux;

   // access phase, no wait states
   assign access    = psel & penable;
   assign wr_access = access & pwrite;

   always_comb begin
      addr_hit = 1'b1;
      rd_mux   = '0;
      case (paddr)
         reg_ctrl: begin
            rd_mux[ctrl_enable_bit] = fetch_enable;
            rd_mux[ctrl_irq_en_bit] = irq_en;
         end
         reg_status: begin
            rd_mux[status_done_bit]   = done_flag;
            rd_mux[status_buffer_bit] = active_buffer;
         end
         reg_frame_count: begin
            rd_mux = frame_count;
         end
         default: begin
            addr_hit = 1'b0;
         end
      endcase
   end

   assign pready  = 1'b1;
   assign pslverr = access & ~addr_hit;
   // unmapped offsets read as zero
   assign prdata  = (access && !pwrite) ? rd_mux : '0;

   // control bits
   always_ff @(posedge cpu_clk_g) begin
      if (rst) begin
         fetch_enable <= 1'b0;
         irq_en       <= 1'b0;
      end else if (wr_access && paddr == reg_ctrl) begin
         fetch_enable <= pwdata[ctrl_enable_bit];
         irq_en       <= pwdata[ctrl_irq_en_bit];
      end
   end

   // sticky done, a new frame wins over a clear in the same cycle
   always_ff @(posedge cpu_clk_g) begin
      if (rst) begin
         done_flag <= 1'b0;
      end else if (frame_done) begin
         done_flag <= 1'b1;
      end else if (wr_access && paddr == reg_status && pwdata[status_done_bit]) begin
         done_flag <= 1'b0;
      end
   end

   // completed frames since reset
   always_ff @(posedge cpu_clk_g) begin
      if (rst) begin
         frame_count <= '0;
      end else if (frame_done) begin
         frame_count <= frame_count + 1'b1;
      end
   end

   assign frame_irq = done_flag & irq_en;

endmodule

// File: source/feeder_regs_pkg.sv
// APB register map of the pixel feeder
// offsets and bit positions for control and status
package feeder_regs_pkg;

   // bus widths
   localparam int apb_addr_width = 4;
   localparam int apb_data_width = 32;

   // register offsets
   localparam logic [apb_addr_width-1:0] reg_ctrl        = 4'h0;
   localparam logic [apb_addr_width-1:0] reg_status      = 4'h4;
   localparam logic [apb_addr_width-1:0] reg_frame_count = 4'h8;

   // control register bits
   localparam int ctrl_enable_bit = 0;
   localparam int ctrl_irq_en_bit = 1;

   // status register bits
   // done is sticky, write 1 to clear
   localparam int status_done_bit   = 0;
   // buffer bit reads 0 for buffer one
   localparam int status_buffer_bit = 1;

endpackage

// File: source/frame_fetcher.sv
`timescale 1ns/10ps
// walks the frame in raster order and issues one DDR read per 8 pixels
// limits outstanding pixels to the buffer depth and swaps buffers per frame
module frame_fetcher #(
   parameter int frame_width  = frame_geom_pkg::frame_width_default,
   parameter int frame_height = frame_geom_pkg::frame_height_default
) (
   input  logic                                      cpu_clk_g,
   input  logic                                      rst,
   input  logic                                      fetch_enable,
   input  logic                                      af_full,
   input  logic                                      pixel_pop,
   output logic                                      af_wr_en,
   output logic [frame_geom_pkg::ddr_addr_width-1:0] af_addr_din,
   output logic                                      frame_done,
   output logic                                      active_buffer
);
   import frame_geom_pkg::*;

   localparam int col_width    = col_block_width + $clog2(pixels_per_request);
   // one extra bit so credit plus a request never wraps
   localparam int credit_width = $clog2(pixel_buffer_depth) + 1;

   localparam logic [col_width-1:0]    last_col     = col_width'(frame_width - pixels_per_request);
   localparam logic [row_width-1:0]    last_row     = row_width'(frame_height - 1);
   localparam logic [col_width-1:0]    col_step     = col_width'(pixels_per_request);
   localparam logic [credit_width-1:0] req_pixels   = credit_width'(pixels_per_request);
   localparam logic [credit_width-1:0] credit_limit = credit_width'(pixel_buffer_depth);

   logic [col_width-1:0]    col;
   logic [row_width-1:0]    row;
   logic                    accept;
   logic                    last_block;
   logic [credit_width-1:0] credit;
   logic [credit_width-1:0] credit_next;
   logic                    room;
   ddr_addr_t               req_addr;

   assign accept     = af_wr_en & ~af_full;
   assign last_block = (col == last_col) && (row == last_row);

   // pixels requested but not yet popped
   always_comb begin
      credit_next = credit;
      if (accept) begin
         credit_next = credit_next + req_pixels;
      end
      if (pixel_pop) begin
         credit_next = credit_next - 1'b1;
      end
   end

   assign room = (credit_next + req_pixels) <= credit_limit;

   // request offer, held through af_full
   // dropping the enable withdraws it
   always_ff @(posedge cpu_clk_g) begin
      if (rst) begin
         af_wr_en <= 1'b0;
      end else if (!fetch_enable) begin
         af_wr_en <= 1'b0;
      end else if (af_wr_en && af_full) begin
         af_wr_en <= 1'b1;
      end else begin
         af_wr_en <= room;
      end
   end

   // raster walk, credit and buffer swap
   always_ff @(posedge cpu_clk_g) begin
      if (rst) begin
         col           <= '0;
         row           <= '0;
         credit        <= '0;
         active_buffer <= 1'b0;
         frame_done    <= 1'b0;
      end else begin
         credit     <= credit_next;
         frame_done <= accept & last_block;
         if (accept) begin
            if (col == last_col) begin
               col <= '0;
               if (row == last_row) begin
                  row           <= '0;
                  active_buffer <= ~active_buffer;
               end else begin
                  row <= row + 1'b1;
               end
            end else begin
               col <= col + col_step;
            end
         end
      end
   end

   // address built from the raster, column in blocks of eight
   always_comb begin
      req_addr                  = '0;
      req_addr.fields.buffer_id = active_buffer ? buffer_two : buffer_one;
      req_addr.fields.row       = row;
      req_addr.fields.col_block = col[col_width-1 -: col_block_width];
   end

   assign af_addr_din = req_addr.raw;

endmodule

// File: source/frame_geom_pkg.sv
// frame geometry, DDR address layout and pixel word types
// shared by the fetch engine, the pixel buffer and the top level
package frame_geom_pkg;

   // default frame size, overridden at the top level
   localparam int frame_width_default  = 800;
   localparam int frame_height_default = 600;

   // request and beat sizing
   localparam int pixels_per_request = 8;
   localparam int beats_per_request  = 2;
   localparam int pixels_per_beat    = pixels_per_request / beats_per_request;
   localparam int pixel_buffer_depth = 2048;

   // data path widths
   localparam int beat_width  = 128;
   localparam int pixel_width = 32;
   localparam int rgb_width   = 24;

   // address layout
   localparam int ddr_addr_width  = 31;
   localparam int buffer_id_width = 6;
   localparam int row_width       = 10;
   localparam int col_block_width = 7;

   // one-hot frame buffer identifiers
   localparam logic [buffer_id_width-1:0] buffer_one = 6'b000001;
   localparam logic [buffer_id_width-1:0] buffer_two = 6'b000010;

   typedef logic [pixel_width-1:0] pixel_t;

   // field view, high to low
   typedef struct packed {
      logic [5:0]                 zero_hi;
      logic [buffer_id_width-1:0] buffer_id;
      logic [row_width-1:0]       row;
      logic [col_block_width-1:0] col_block;
      logic [1:0]                 zero_lo;
   } ddr_addr_fields_t;

   // same address word seen raw or by fields
   typedef union packed {
      logic [ddr_addr_width-1:0] raw;
      ddr_addr_fields_t          fields;
   } ddr_addr_t;

endpackage

// File: source/pixel_feeder_top.sv
`timescale 1ns/10ps
// pixel feeder, keeps the video stream fed from the DDR frame buffers
// registers, fetch engine and pixel buffer on one clock
module pixel_feeder_top #(
   parameter int frame_width  = frame_geom_pkg::frame_width_default,
   parameter int frame_height = frame_geom_pkg::frame_height_default
) (
   input  logic                                       cpu_clk_g,
   input  logic                                       rst,
   input  logic                                       psel,
   input  logic                                       penable,
   input  logic                                       pwrite,
   input  logic [feeder_regs_pkg::apb_addr_width-1:0] paddr,
   input  logic [feeder_regs_pkg::apb_data_width-1:0] pwdata,
   output logic [feeder_regs_pkg::apb_data_width-1:0] prdata,
   output logic                                       pready,
   output logic                                       pslverr,
   input  logic                                       rdf_valid,
   input  logic [frame_geom_pkg::beat_width-1:0]      rdf_dout,
   input  logic                                       af_full,
   output logic                                       rdf_rd_en,
   output logic                                       af_wr_en,
   output logic [frame_geom_pkg::ddr_addr_width-1:0]  af_addr_din,
   output logic [frame_geom_pkg::rgb_width-1:0]       video,
   output logic                                       video_valid,
   input  logic                                       video_ready,
   output logic                                       frame_irq
);

   logic fetch_enable;
   logic frame_done;
   logic active_buffer;
   logic pixel_pop;

   // read data is always taken
   assign rdf_rd_en = 1'b1;

   feeder_regs u_regs (
      .cpu_clk_g     (cpu_clk_g),
      .rst           (rst),
      .psel          (psel),
      .penable       (penable),
      .pwrite        (pwrite),
      .paddr         (paddr),
      .pwdata        (pwdata),
      .prdata        (prdata),
      .pready        (pready),
      .pslverr       (pslverr),
      .frame_done    (frame_done),
      .active_buffer (active_buffer),
      .fetch_enable  (fetch_enable),
      .frame_irq     (frame_irq)
   );

   frame_fetcher #(
      .frame_width  (frame_width),
      .frame_height (frame_height)
   ) u_fetcher (
      .cpu_clk_g     (cpu_clk_g),
      .rst           (rst),
      .fetch_enable  (fetch_enable),
      .af_full       (af_full),
      .pixel_pop     (pixel_pop),
      .af_wr_en      (af_wr_en),
      .af_addr_din   (af_addr_din),
      .frame_done    (frame_done),
      .active_buffer (active_buffer)
   );

   pixel_fifo u_fifo (
      .cpu_clk_g   (cpu_clk_g),
      .rst         (rst),
      .rdf_valid   (rdf_valid),
      .rdf_dout    (rdf_dout),
      .video_ready (video_ready),
      .video       (video),
      .video_valid (video_valid),
      .pixel_pop   (pixel_pop)
   );

endmodule

// File: source/pixel_fifo.sv
`timescale 1ns/10ps
// synchronous pixel buffer, 128-bit DDR beats in and 32-bit pixels out
// the fetcher credit keeps it from ever overflowing
module pixel_fifo (
   input  logic                                 cpu_clk_g,
   input  logic                                 rst,
   input  logic                                 rdf_valid,
   input  logic [frame_geom_pkg::beat_width-1:0] rdf_dout,
   input  logic                                 video_ready,
   output logic [frame_geom_pkg::rgb_width-1:0]  video,
   output logic                                 video_valid,
   output logic                                 pixel_pop
);
   import frame_geom_pkg::*;

   localparam int entries    = pixel_buffer_depth / pixels_per_beat;
   localparam int ptr_width  = $clog2(entries);
   localparam int lane_width = $clog2(pixels_per_beat);

   localparam logic [lane_width-1:0] last_lane = lane_width'(pixels_per_beat - 1);

   logic [beat_width-1:0] store [entries];
   logic [ptr_width-1:0]  wr_ptr;
   logic [ptr_width-1:0]  rd_ptr;
   logic [ptr_width:0]    fill;
   logic [lane_width-1:0] lane;
   logic [beat_width-1:0] head;
   pixel_t                head_pixel;
   logic                  retire;

   // head entry read without a register
   assign head       = store[rd_ptr];
   assign head_pixel = head[lane*pixel_width +: pixel_width];
   assign video      = head_pixel[rgb_width-1:0];

   assign video_valid = (fill != '0);
   assign pixel_pop   = video_valid & video_ready;
   assign retire      = pixel_pop & (lane == last_lane);

   always_ff @(posedge cpu_clk_g) begin
      if (rdf_valid) begin
         store[wr_ptr] <= rdf_dout;
      end
   end

   always_ff @(posedge cpu_clk_g) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         fill   <= '0;
         lane   <= '0;
      end else begin
         if (rdf_valid) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         // lane 0 first, entry retires after lane 3
         if (retire) begin
            lane   <= '0;
            rd_ptr <= rd_ptr + 1'b1;
         end else if (pixel_pop) begin
            lane <= lane + 1'b1;
         end
         case ({rdf_valid, retire})
            2'b10:   fill <= fill + 1'b1;
            2'b01:   fill <= fill - 1'b1;
            default: fill <= fill;
         endcase
      end
   end

endmodule

// File: testbench/pixel_feeder_assertions.sv
`timescale 1ns/10ps
// concurrent checks on the fetcher request handshake and frame pulse
// bound into every frame_fetcher instance
module pixel_feeder_assertions (
   input logic        cpu_clk_g,
   input logic        rst,
   input logic        fetch_enable,
   input logic        af_full,
   input logic        af_wr_en,
   input logic [30:0] af_addr_din,
   input logic        frame_done
);

   int fail_count = 0;

   // a held request keeps its address while the FIFO is full
   hold_while_full: assert property (@(posedge cpu_clk_g) disable iff (rst)
      af_wr_en && af_full && fetch_enable |=> af_wr_en && $stable(af_addr_din))
      else begin
         $error("request changed while the address FIFO was full");
         fail_count++;
      end

   no_request_when_disabled: assert property (@(posedge cpu_clk_g) disable iff (rst)
      !fetch_enable && $past(!fetch_enable) |-> !af_wr_en)
      else begin
         $error("request offered after fetching was disabled");
         fail_count++;
      end

   single_frame_pulse: assert property (@(posedge cpu_clk_g) disable iff (rst)
      frame_done |=> !frame_done)
      else begin
         $error("frame done pulse lasted more than one cycle");
         fail_count++;
      end

endmodule

bind frame_fetcher pixel_feeder_assertions u_assert (
   .cpu_clk_g    (cpu_clk_g),
   .rst          (rst),
   .fetch_enable (fetch_enable),
   .af_full      (af_full),
   .af_wr_en     (af_wr_en),
   .af_addr_din  (af_addr_din),
   .frame_done   (frame_done)
);

// File: testbench/tb_checker.sv
`timescale 1ns/10ps
// scoreboard for the pixel feeder, models the raster and the responder data rule
// checks every accepted address and every transferred pixel, tracks outstanding pixels
module tb_checker #(
   parameter int frame_width  = 64,
   parameter int frame_height = 4
) (
   input  logic        cpu_clk_g,
   input  logic        rst,
   input  logic        af_wr_en,
   input  logic        af_full,
   input  logic [30:0] af_addr_din,
   input  logic [23:0] video,
   input  logic        video_valid,
   input  logic        video_ready,
   output int          frames_seen,
   output int          requests_seen,
   output int          pixels_seen,
   output int          outstanding
);
   import frame_geom_pkg::*;

   int        err_count;
   int        frames;
   int        reqs;
   int        pixels;
   int        credit;
   int        req_row;
   int        req_col;
   bit        req_buf;
   int        pix_row;
   int        pix_col;
   bit        pix_buf;
   bit        wrapped;
   ddr_addr_t got;

   assign frames_seen   = frames;
   assign requests_seen = reqs;
   assign pixels_seen   = pixels;
   assign outstanding   = credit;

   function automatic logic [5:0] buffer_id(bit sel);
      return sel ? buffer_two : buffer_one;
   endfunction

   // responder rule: low 24 address bits shifted by 3, plus pixel index in block
   function automatic logic [23:0] expected_pixel(bit sel, int row, int col);
      ddr_addr_t   a;
      logic [31:0] v;
      a                  = '0;
      a.fields.buffer_id = buffer_id(sel);
      a.fields.row       = row[9:0];
      a.fields.col_block = 7'(col / 8);
      v = (32'(a.raw[23:0]) << 3) + 32'(col % 8);
      return v[23:0];
   endfunction

   task automatic compare_value(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
      if (expected !== actual) begin
         err_count++;
         $display("FAILED %s expected %h actual %h", name, expected, actual);
      end
   endtask

   task automatic note_failure(input string what);
      err_count++;
      $display("ERROR %s", what);
   endtask

   function automatic int error_count();
      return err_count;
   endfunction

   task automatic print_summary(input int assertion_fails);
      $display("errors %0d, assertion failures %0d, frames %0d, requests %0d, pixels %0d",
               err_count, assertion_fails, frames, reqs, pixels);
   endtask

   // one raster step, returns 1 at the end of a frame
   task automatic step_raster(inout int row, inout int col, inout bit sel, output bit wrap);
      wrap = 1'b0;
      col  = col + 8;
      if (col == frame_width) begin
         col = 0;
         if (row == frame_height - 1) begin
            row  = 0;
            sel  = ~sel;
            wrap = 1'b1;
         end else begin
            row = row + 1;
         end
      end
   endtask

   initial begin
      err_count = 0;
   end

   always @(posedge cpu_clk_g) begin
      if (rst) begin
         frames  = 0;
         reqs    = 0;
         pixels  = 0;
         credit  = 0;
         req_row = 0;
         req_col = 0;
         req_buf = 1'b0;
         pix_row = 0;
         pix_col = 0;
         pix_buf = 1'b0;
      end else begin
         if (af_wr_en && !af_full) begin
            got.raw = af_addr_din;
            compare_value("af_addr_din.buffer_id", buffer_id(req_buf), got.fields.buffer_id);
            compare_value("af_addr_din.row", req_row, got.fields.row);
            compare_value("af_addr_din.col_block", req_col / 8, got.fields.col_block);
            compare_value("af_addr_din.zero_hi", 0, got.fields.zero_hi);
            compare_value("af_addr_din.zero_lo", 0, got.fields.zero_lo);
            reqs++;
            credit += pixels_per_request;
            step_raster(req_row, req_col, req_buf, wrapped);
            if (wrapped) begin
               frames++;
            end
         end
         if (video_valid && video_ready) begin
            compare_value("video", expected_pixel(pix_buf, pix_row, pix_col), video);
            pixels++;
            credit--;
            pix_col++;
            if (pix_col % 8 == 0) begin
               pix_col -= 8;
               step_raster(pix_row, pix_col, pix_buf, wrapped);
            end
         end
         if (credit > pixel_buffer_depth) begin
            note_failure("more pixels requested than the pixel buffer can hold");
         end
         if (credit < 0) begin
            note_failure("a pixel was transferred that was never requested");
         end
      end
   end

endmodule

// File: testbench/tb_clock_gen.sv
`timescale 1ns/10ps
// testbench clock and reset source, 20 ns period
// reset is held for eight cycles and released on a falling edge
module tb_clock_gen #(
   parameter int period       = 20,
   parameter int reset_cycles = 8
) (
   output logic cpu_clk_g,
   output logic rst
);

   initial begin
      cpu_clk_g = 1'b0;
      forever #(period / 2) cpu_clk_g = ~cpu_clk_g;
   end

   initial begin
      rst = 1'b1;
      repeat (reset_cycles) @(posedge cpu_clk_g);
      @(negedge cpu_clk_g);
      rst = 1'b0;
   end

endmodule

// File: testbench/tb_pixel_feeder.sv
`timescale 1ns/10ps
// top testbench for the pixel feeder on a 64 by 4 frame
// APB traffic, DDR responder model and a random video sink
module tb_pixel_feeder;
   import frame_geom_pkg::*;
   import feeder_regs_pkg::*;

   localparam int          tb_width      = 64;
   localparam int          tb_height     = 4;
   localparam logic [31:0] seed          = 32'hf5d6_ed5f;
   localparam int          apb_timeout   = 20;
   localparam int          frame_timeout = 50000;
   localparam int          drain_timeout = 50000;

   logic         cpu_clk_g;
   logic         rst;
   logic         psel;
   logic         penable;
   logic         pwrite;
   logic [3:0]   paddr;
   logic [31:0]  pwdata;
   logic [31:0]  prdata;
   logic         pready;
   logic         pslverr;
   logic         rdf_valid;
   logic [127:0] rdf_dout;
   logic         af_full;
   logic         rdf_rd_en;
   logic         af_wr_en;
   logic [30:0]  af_addr_din;
   logic [23:0]  video;
   logic         video_valid;
   logic         video_ready;
   logic         frame_irq;

   int frames_seen;
   int requests_seen;
   int pixels_seen;
   int outstanding;

   // responder state
   logic [30:0] pend_addr[$];
   int          pend_due[$];
   int          cycle;
   bit          second_beat;
   logic [30:0] cur_addr;

   tb_clock_gen u_clk (
      .cpu_clk_g (cpu_clk_g),
      .rst       (rst)
   );

   pixel_feeder_top #(
      .frame_width  (tb_width),
      .frame_height (tb_height)
   ) u_dut (
      .cpu_clk_g   (cpu_clk_g),
      .rst         (rst),
      .psel        (psel),
      .penable     (penable),
      .pwrite      (pwrite),
      .paddr       (paddr),
      .pwdata      (pwdata),
      .prdata      (prdata),
      .pready      (pready),
      .pslverr     (pslverr),
      .rdf_valid   (rdf_valid),
      .rdf_dout    (rdf_dout),
      .af_full     (af_full),
      .rdf_rd_en   (rdf_rd_en),
      .af_wr_en    (af_wr_en),
      .af_addr_din (af_addr_din),
      .video       (video),
      .video_valid (video_valid),
      .video_ready (video_ready),
      .frame_irq   (frame_irq)
   );

   tb_checker #(
      .frame_width  (tb_width),
      .frame_height (tb_height)
   ) u_chk (
      .cpu_clk_g     (cpu_clk_g),
      .rst           (rst),
      .af_wr_en      (af_wr_en),
      .af_full       (af_full),
      .af_addr_din   (af_addr_din),
      .video         (video),
      .video_valid   (video_valid),
      .video_ready   (video_ready),
      .frames_seen   (frames_seen),
      .requests_seen (requests_seen),
      .pixels_seen   (pixels_seen),
      .outstanding   (outstanding)
   );

   // lane i of beat b is the shifted address plus 4b+i
   function automatic logic [127:0] make_beat(logic [30:0] addr, int b);
      logic [127:0] beat;
      for (int i = 0; i < 4; i++) begin
         beat[32*i +: 32] = (32'(addr[23:0]) << 3) + 32'(4 * b + i);
      end
      return beat;
   endfunction

   // capture accepted requests with their return time
   always @(posedge cpu_clk_g) begin
      if (rst) begin
         cycle <= 0;
      end else begin
         cycle <= cycle + 1;
         if (af_wr_en && !af_full) begin
            pend_addr.push_back(af_addr_din);
            pend_due.push_back(cycle + 2 + int'($urandom_range(10)));
         end
      end
   end

   // DDR read data, FIFO full and video sink, all on the falling edge
   always @(negedge cpu_clk_g) begin
      if (rst) begin
         rdf_valid   = 1'b0;
         af_full     = 1'b0;
         video_ready = 1'b0;
         second_beat = 1'b0;
      end else begin
         af_full     = ($urandom % 100) < 20;
         video_ready = ($urandom % 100) < 60;
         rdf_valid   = 1'b0;
         if (second_beat) begin
            rdf_valid   = 1'b1;
            rdf_dout    = make_beat(cur_addr, 1);
            second_beat = 1'b0;
         end else if (pend_addr.size() > 0 && pend_due[0] <= cycle) begin
            cur_addr    = pend_addr.pop_front();
            void'(pend_due.pop_front());
            rdf_valid   = 1'b1;
            rdf_dout    = make_beat(cur_addr, 0);
            second_beat = 1'b1;
         end
      end
   end

   task automatic apb_access(input logic [3:0] addr, input bit write,
                             input logic [31:0] wdata, output logic [31:0] rdata,
                             output logic err);
      int n;
      @(negedge cpu_clk_g);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = write;
      paddr   = addr;
      pwdata  = wdata;
      @(negedge cpu_clk_g);
      penable = 1'b1;
      n       = 0;
      #5;
      while (!pready && n < apb_timeout) begin
         @(negedge cpu_clk_g);
         #5;
         n++;
      end
      if (!pready) begin
         u_chk.note_failure("APB access never completed");
      end
      rdata = prdata;
      err   = pslverr;
      @(negedge cpu_clk_g);
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_write(input logic [3:0] addr, input logic [31:0] data);
      logic [31:0] unused;
      logic        err;
      apb_access(addr, 1'b1, data, unused, err);
      u_chk.compare_value("pslverr", 0, err);
   endtask

   task automatic apb_check(input logic [3:0] addr, input string name,
                            input logic [31:0] expected);
      logic [31:0] data;
      logic        err;
      apb_access(addr, 1'b0, '0, data, err);
      u_chk.compare_value("pslverr", 0, err);
      u_chk.compare_value(name, expected, data);
   endtask

   // run fetching for some frames, stop, drain, then check the registers
   task automatic run_frames(input bit irq_en, input int count);
      int target;
      int reqs;
      int n;
      target = frames_seen + count;
      apb_write(reg_ctrl, {30'd0, irq_en, 1'b1});
      n = 0;
      while (frames_seen < target && n < frame_timeout) begin
         @(negedge cpu_clk_g);
         n++;
      end
      if (frames_seen < target) begin
         u_chk.note_failure("frames did not complete in time");
      end
      if (irq_en) begin
         n = 0;
         while (!frame_irq && n < frame_timeout) begin
            @(negedge cpu_clk_g);
            n++;
         end
         if (!frame_irq) begin
            u_chk.note_failure("frame interrupt never rose");
         end
      end
      apb_write(reg_ctrl, {30'd0, irq_en, 1'b0});
      // one request can still be accepted on the edge after the write
      repeat (3) @(negedge cpu_clk_g);
      reqs = requests_seen;
      n    = 0;
      while ((outstanding != 0 || pend_addr.size() != 0 || second_beat)
             && n < drain_timeout) begin
         @(negedge cpu_clk_g);
         n++;
      end
      if (outstanding != 0) begin
         u_chk.note_failure("requested pixels were not drained");
      end
      u_chk.compare_value("requests_after_disable", reqs, requests_seen);
      u_chk.compare_value("video_valid", 0, video_valid);
      u_chk.compare_value("af_wr_en", 0, af_wr_en);
      apb_check(reg_frame_count, "prdata.frame_count", frames_seen);
      apb_check(reg_status, "prdata.status", {30'd0, 1'(frames_seen % 2), 1'b1});
      u_chk.compare_value("frame_irq", irq_en, frame_irq);
      apb_write(reg_status, 32'h1);
      apb_check(reg_status, "prdata.status", {30'd0, 1'(frames_seen % 2), 1'b0});
      u_chk.compare_value("frame_irq", 0, frame_irq);
   endtask

   initial begin
      logic [31:0] data;
      logic        err;
      int          n;
      int          assert_fails;
      void'($urandom(seed));
      psel        = 1'b0;
      penable     = 1'b0;
      pwrite      = 1'b0;
      paddr       = '0;
      pwdata      = '0;
      rdf_valid   = 1'b0;
      rdf_dout    = '0;
      af_full     = 1'b0;
      video_ready = 1'b0;
      second_beat = 1'b0;
      n = 0;
      while (rst !== 1'b0 && n < 100) begin
         @(negedge cpu_clk_g);
         n++;
      end
      if (rst !== 1'b0) begin
         u_chk.note_failure("reset was never released");
      end
      u_chk.compare_value("af_wr_en", 0, af_wr_en);
      u_chk.compare_value("video_valid", 0, video_valid);
      u_chk.compare_value("frame_irq", 0, frame_irq);
      u_chk.compare_value("rdf_rd_en", 1, rdf_rd_en);

      // unmapped offset, read and write
      apb_access(4'hc, 1'b0, '0, data, err);
      u_chk.compare_value("pslverr", 1, err);
      u_chk.compare_value("prdata", 0, data);
      apb_access(4'hc, 1'b1, 32'hffff_ffff, data, err);
      u_chk.compare_value("pslverr", 1, err);
      apb_check(reg_ctrl, "prdata.ctrl", 0);

      // ten frames request more pixels than the buffer holds, so credit throttles
      run_frames(1'b1, 10);
      run_frames(1'b0, 2);
      run_frames(1'b1, 2);

      assert_fails = u_dut.u_fetcher.u_assert.fail_count;
      u_chk.print_summary(assert_fails);
      if (u_chk.error_count() == 0 && assert_fails == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule
